// File: verilog.f
+incdir+testbench
rtl/soc_pkg.sv
rtl/bus_controller.sv
rtl/boot_rom.sv
rtl/block_ram.sv
rtl/machine_timer.sv
rtl/soc_top.sv
testbench/tb_soc.sv

// File: rtl/boot_rom.hex
// One 32-bit word per line, word addresses 0 to 15
100002b7
00028293
0002a303
00130313
0062a023
a0000537
00052583
00452603
0085a023
00000013
00000013
ffdff06f
deadbeef
cafef00d
12345678
0badc0de

// File: testbench/tb_soc_tests.svh
`ifndef TB_SOC_TESTS_SVH
`define TB_SOC_TESTS_SVH

// ======================================================================
// Checking helpers and bus master
// ======================================================================

task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
	assert (actual === expected) else begin
		$display("ERR %s: expected %h, actual %h", test_name, expected, actual);
		value_errors++;
	end
endtask

task automatic check_true(input logic condition, input string description);
	assert (condition === 1'b1) else begin
		$display("Failure: %s", description);
		other_errors++;
	end
endtask

// One request, then wait for o_ready and check it lands on cycle 3 only
task automatic bus_access(input string test_name, input logic rw, input logic [3:0] region,
		input logic [25:0] word, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic fault);
	int ready_cycle;
	int cycle;
	ready_cycle = 0;
	rdata = 'x;
	fault = 1'bx;
	@(posedge clock);
	#5;
	i_request                      = 1'b1;
	i_rw                           = rw;
	i_address.region_view.region   = region;
	i_address.region_view.offset   = {word, 2'b00};
	i_wdata                        = wdata;
	@(posedge clock);
	#5;
	sample_cycle = cycle_count;
	i_request    = 1'b0;
	for (cycle = 1; cycle <= 8 && ready_cycle == 0; cycle++) begin
		@(posedge clock);
		#5;
		if (o_ready) begin
			ready_cycle = cycle;
			rdata       = o_rdata;
			fault       = o_fault;
		end
	end
	check_true(ready_cycle != 0, {test_name, ": no o_ready within 8 cycles of the request"});
	if (ready_cycle != 0) begin
		check_value({test_name, " ready cycle"}, 32'd3, ready_cycle);
		@(posedge clock);
		#5;
		check_true(!o_ready, {test_name, ": o_ready high for more than one cycle"});
	end
endtask

// ======================================================================
// Directed tests
// ======================================================================

task automatic response_timing();
	logic [31:0] rdata;
	logic        fault;
	// Idle bus after reset
	repeat (8) begin
		@(posedge clock);
		#5;
		check_true(!o_ready, "o_ready rose after reset without a request");
	end
	bus_access("timing_rom", 1'b0, soc_pkg::REGION_ROM, 26'd0, '0, rdata, fault);
	bus_access("timing_ram", 1'b0, soc_pkg::REGION_RAM, 26'd0, '0, rdata, fault);
	bus_access("timing_timer", 1'b0, soc_pkg::REGION_TIMER, 26'd0, '0, rdata, fault);
	bus_access("timing_unmapped", 1'b0, 4'h7, 26'd0, '0, rdata, fault);
endtask

task automatic rom_contents();
	logic [31:0] rdata;
	logic        fault;
	int          index;
	for (index = 0; index < soc_pkg::ROM_WORDS; index++) begin
		bus_access("rom_read", 1'b0, soc_pkg::REGION_ROM, 26'(index), '0, rdata, fault);
		check_value($sformatf("rom_read word %0d", index), rom_model[index], rdata);
		check_value("rom_read fault", 32'd0, {31'd0, fault});
	end
	// Offset 16 wraps onto word 0
	bus_access("rom_alias", 1'b0, soc_pkg::REGION_ROM, 26'(soc_pkg::ROM_WORDS), '0, rdata, fault);
	check_value("rom_alias", rom_model[0], rdata);
	bus_access("rom_write", 1'b1, soc_pkg::REGION_ROM, 26'd3, ~rom_model[3], rdata, fault);
	bus_access("rom_write", 1'b0, soc_pkg::REGION_ROM, 26'd3, '0, rdata, fault);
	check_value("rom_write", rom_model[3], rdata);
endtask

task automatic ram_read_write();
	logic [31:0] ram_model [soc_pkg::RAM_WORDS];
	bit          ram_written [soc_pkg::RAM_WORDS];
	int          written [$];
	logic [31:0] rdata;
	logic [31:0] wdata;
	logic        fault;
	int          count;
	int          word;
	foreach (ram_written[i]) ram_written[i] = 1'b0;
	for (count = 0; count < RAM_WRITES; count++) begin
		word  = $urandom_range(soc_pkg::RAM_WORDS - 1);
		wdata = $urandom;
		bus_access("ram_write", 1'b1, soc_pkg::REGION_RAM, 26'(word), wdata, rdata, fault);
		// Old word comes back on a repeated address
		if (ram_written[word]) begin
			check_value("ram_write old word", ram_model[word], rdata);
		end
		ram_model[word]   = wdata;
		ram_written[word] = 1'b1;
		written.push_back(word);
	end
	foreach (written[i]) begin
		bus_access("ram_read", 1'b0, soc_pkg::REGION_RAM, 26'(written[i]), '0, rdata, fault);
		check_value($sformatf("ram_read word %0d", written[i]), ram_model[written[i]], rdata);
		check_value("ram_read fault", 32'd0, {31'd0, fault});
	end
	// Word RAM_WORDS + n lands on word n
	word  = written[0];
	wdata = $urandom;
	bus_access("ram_alias", 1'b1, soc_pkg::REGION_RAM, 26'(soc_pkg::RAM_WORDS + word), wdata,
		rdata, fault);
	check_value("ram_alias old word", ram_model[word], rdata);
	bus_access("ram_alias", 1'b0, soc_pkg::REGION_RAM, 26'(word), '0, rdata, fault);
	check_value("ram_alias", wdata, rdata);
endtask

task automatic unmapped_fault();
	logic [3:0]  regions [3];
	logic [31:0] rdata;
	logic        fault;
	regions[0] = 4'h2;
	regions[1] = 4'h5;
	regions[2] = 4'hF;
	foreach (regions[i]) begin
		bus_access("fault_read", 1'b0, regions[i], 26'h40, '0, rdata, fault);
		check_value("fault_read fault", 32'd1, {31'd0, fault});
		check_value("fault_read data", 32'd0, rdata);
		bus_access("fault_write", 1'b1, regions[i], 26'h41, 32'h5a5a_a5a5, rdata, fault);
		check_value("fault_write fault", 32'd1, {31'd0, fault});
		check_value("fault_write data", 32'd0, rdata);
	end
	bus_access("fault_then_ram", 1'b0, soc_pkg::REGION_RAM, 26'd0, '0, rdata, fault);
	check_value("fault_then_ram fault", 32'd0, {31'd0, fault});
endtask

task automatic timer_counting();
	logic [31:0] rdata;
	logic [31:0] first_time;
	logic        fault;
	int          first_cycle;
	int          expected_ticks;
	int          actual_ticks;
	check_true(!o_timer_interrupt, "timer interrupt high after reset");
	bus_access("timer_time_hi", 1'b0, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_TIME_HI),
		'0, rdata, fault);
	check_value("timer_time_hi", 32'd0, rdata);
	bus_access("timer_time_lo", 1'b0, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_TIME_LO),
		'0, first_time, fault);
	first_cycle = sample_cycle;
	repeat (TIMER_GAP) @(posedge clock);
	bus_access("timer_time_lo", 1'b0, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_TIME_LO),
		'0, rdata, fault);
	expected_ticks = (sample_cycle - first_cycle) / soc_pkg::TIMER_TICK_DIVIDER;
	actual_ticks   = rdata - first_time;
	assert (actual_ticks >= expected_ticks - 1 && actual_ticks <= expected_ticks + 1) else begin
		$display("ERR timer_counting: expected %0d ticks, actual %0d", expected_ticks,
			actual_ticks);
		value_errors++;
	end
endtask

task automatic timer_interrupt();
	logic [31:0] rdata;
	logic [31:0] now;
	logic        fault;
	int          waited;
	bus_access("timer_cmp_hi", 1'b1, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_CMP_HI),
		32'd0, rdata, fault);
	check_true(!o_timer_interrupt, "timer interrupt rose while compare low half was all ones");
	bus_access("timer_now", 1'b0, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_TIME_LO),
		'0, now, fault);
	bus_access("timer_cmp_lo", 1'b1, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_CMP_LO),
		now + 32'd10, rdata, fault);
	check_true(!o_timer_interrupt, "timer interrupt high before time reached compare");
	waited = 0;
	while (!o_timer_interrupt && waited < 10 * soc_pkg::TIMER_TICK_DIVIDER + 8) begin
		@(posedge clock);
		#5;
		waited++;
	end
	check_true(o_timer_interrupt, "timer interrupt did not rise after time reached compare");
	bus_access("timer_cmp_lo", 1'b0, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_CMP_LO),
		'0, rdata, fault);
	check_value("timer_cmp_lo readback", now + 32'd10, rdata);
	// Compare high half all ones pushes compare far past time
	bus_access("timer_cmp_off", 1'b1, soc_pkg::REGION_TIMER, 26'(soc_pkg::TIMER_REG_CMP_HI),
		'1, rdata, fault);
	// bus_access returns one cycle after o_ready, so three more make four
	waited = 0;
	while (o_timer_interrupt && waited < 3) begin
		@(posedge clock);
		#5;
		waited++;
	end
	check_true(!o_timer_interrupt, "timer interrupt stayed high after compare moved past time");
endtask

`endif

// File: testbench/tb_soc.sv
module tb_soc;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 16;
	localparam int RAM_WRITES   = 128;
	localparam int TIMER_GAP    = 40;
	// Tests take about 2000 cycles, mostly the RAM pass at 6 cycles per access
	localparam int TIMEOUT_CYCLES = 4000;

	logic                           clock;
	logic                           i_reset;
	logic                           i_request;
	logic                           i_rw;
	soc_pkg::bus_address_t          i_address;
	logic [soc_pkg::DATA_WIDTH-1:0] i_wdata;
	logic [soc_pkg::DATA_WIDTH-1:0] o_rdata;
	logic                           o_ready;
	logic                           o_fault;
	logic                           o_timer_interrupt;

	int value_errors;
	int other_errors;
	int cycle_count;
	int sample_cycle;

	// Reference copy of the ROM image
	logic [soc_pkg::DATA_WIDTH-1:0] rom_model [soc_pkg::ROM_WORDS];

	soc_top dut0 (
		.clock(clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_fault(o_fault),
		.o_timer_interrupt(o_timer_interrupt)
	);

	`include "tb_soc_tests.svh"

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Cycle counter doubling as the run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		value_errors = 0;
		other_errors = 0;
		sample_cycle = 0;
		i_reset      = 1'b1;
		i_request    = 1'b0;
		i_rw         = 1'b0;
		i_address    = '0;
		i_wdata      = '0;
		void'($urandom(9825));
		$readmemh("rtl/boot_rom.hex", rom_model);

		repeat (RESET_CYCLES) @(posedge clock);
		#5;
		i_reset = 1'b0;

		response_timing();
		timer_counting();
		rom_contents();
		ram_read_write();
		unmapped_fault();
		timer_interrupt();

		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: rtl/soc_top.sv
module soc_top (
	input  logic                            clock,
	input  logic                            i_reset,
	input  logic                            i_request,
	input  logic                            i_rw,
	input  soc_pkg::bus_address_t           i_address,
	input  logic [soc_pkg::DATA_WIDTH-1:0]  i_wdata,
	output logic [soc_pkg::DATA_WIDTH-1:0]  o_rdata,
	output logic                            o_ready,
	output logic                            o_fault,
	output logic                            o_timer_interrupt
);

	// Shared target-side bus
	logic                           target_rw;
	soc_pkg::bus_address_t          target_address;
	logic [soc_pkg::DATA_WIDTH-1:0] target_wdata;

	// Per-target strobe, ready and read data
	logic                           rom_request;
	logic                           rom_ready;
	logic [soc_pkg::DATA_WIDTH-1:0] rom_rdata;
	logic                           ram_request;
	logic                           ram_ready;
	logic [soc_pkg::DATA_WIDTH-1:0] ram_rdata;
	logic                           timer_request;
	logic                           timer_ready;
	logic [soc_pkg::DATA_WIDTH-1:0] timer_rdata;

	bus_controller bus0 (
		.clock(clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_fault(o_fault),
		.o_target_rw(target_rw),
		.o_target_address(target_address),
		.o_target_wdata(target_wdata),
		.o_rom_request(rom_request),
		.o_ram_request(ram_request),
		.o_timer_request(timer_request),
		.i_rom_ready(rom_ready),
		.i_rom_rdata(rom_rdata),
		.i_ram_ready(ram_ready),
		.i_ram_rdata(ram_rdata),
		.i_timer_ready(timer_ready),
		.i_timer_rdata(timer_rdata)
	);

	boot_rom rom0 (
		.clock(clock),
		.i_request(rom_request),
		.i_address(target_address),
		.o_rdata(rom_rdata),
		.o_ready(rom_ready)
	);

	block_ram ram0 (
		.clock(clock),
		.i_request(ram_request),
		.i_rw(target_rw),
		.i_address(target_address),
		.i_wdata(target_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	machine_timer timer0 (
		.clock(clock),
		.i_reset(i_reset),
		.i_request(timer_request),
		.i_rw(target_rw),
		.i_address(target_address),
		.i_wdata(target_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_interrupt(o_timer_interrupt)
	);

endmodule

// File: rtl/machine_timer.sv
module machine_timer (
	input  logic                            clock,
	input  logic                            i_reset,
	input  logic                            i_request,
	input  logic                            i_rw,
	input  soc_pkg::bus_address_t           i_address,
	input  logic [soc_pkg::DATA_WIDTH-1:0]  i_wdata,
	output logic [soc_pkg::DATA_WIDTH-1:0]  o_rdata,
	output logic                            o_ready,
	output logic                            o_interrupt
);

	localparam int PRESCALE_BITS = $clog2(soc_pkg::TIMER_TICK_DIVIDER);
	localparam int DW            = soc_pkg::DATA_WIDTH;

	logic [PRESCALE_BITS-1:0]         prescale;
	logic                             tick;
	logic [soc_pkg::TIMER_WIDTH-1:0]  time_count;
	logic [soc_pkg::TIMER_WIDTH-1:0]  compare;
	logic [2:0]                       reg_index;

	assign reg_index = i_address.word_view.word[2:0];
	assign tick      = prescale == PRESCALE_BITS'(soc_pkg::TIMER_TICK_DIVIDER - 1);

	// Level interrupt, stays high until compare moves past time
	assign o_interrupt = time_count >= compare;

	// ======================================================================
	// Prescaler, time counter and compare register
	// ======================================================================

	always_ff @(posedge clock) begin
		if (i_reset) begin
			prescale   <= '0;
			time_count <= '0;
			compare    <= '1;
			o_ready    <= 1'b0;
		end else begin
			o_ready <= i_request;

			if (tick) begin
				prescale   <= '0;
				time_count <= time_count + 1'b1;
			end else begin
				prescale <= prescale + 1'b1;
			end

			// Time halves are read-only
			if (i_request && i_rw) begin
				case (reg_index)
					soc_pkg::TIMER_REG_CMP_LO: compare[DW-1:0] <= i_wdata;
					soc_pkg::TIMER_REG_CMP_HI: compare[2*DW-1:DW] <= i_wdata;
					default: ;
				endcase
			end
		end
	end

	// Read returns the current half, unused indices read zero
	always_ff @(posedge clock) begin
		if (i_request) begin
			case (reg_index)
				soc_pkg::TIMER_REG_TIME_LO: o_rdata <= time_count[DW-1:0];
				soc_pkg::TIMER_REG_TIME_HI: o_rdata <= time_count[2*DW-1:DW];
				soc_pkg::TIMER_REG_CMP_LO:  o_rdata <= compare[DW-1:0];
				soc_pkg::TIMER_REG_CMP_HI:  o_rdata <= compare[2*DW-1:DW];
				default:                    o_rdata <= '0;
			endcase
		end
	end

endmodule

// File: rtl/block_ram.sv
module block_ram (
	input  logic                            clock,
	input  logic                            i_request,
	input  logic                            i_rw,
	input  soc_pkg::bus_address_t           i_address,
	input  logic [soc_pkg::DATA_WIDTH-1:0]  i_wdata,
	output logic [soc_pkg::DATA_WIDTH-1:0]  o_rdata,
	output logic                            o_ready
);

	logic [soc_pkg::DATA_WIDTH-1:0] mem [soc_pkg::RAM_WORDS];
	logic [$clog2(soc_pkg::RAM_WORDS)-1:0] index;

	assign index = i_address.word_view.word[$clog2(soc_pkg::RAM_WORDS)-1:0];

	// Read-before-write, so a write returns the old word
	always_ff @(posedge clock) begin
		o_ready <= i_request;
		if (i_request) begin
			o_rdata <= mem[index];
			if (i_rw) begin
				mem[index] <= i_wdata;
			end
		end
	end

endmodule

// File: rtl/boot_rom.sv
module boot_rom (
	input  logic                            clock,
	input  logic                            i_request,
	input  soc_pkg::bus_address_t           i_address,
	output logic [soc_pkg::DATA_WIDTH-1:0]  o_rdata,
	output logic                            o_ready
);

	logic [soc_pkg::DATA_WIDTH-1:0] rom [soc_pkg::ROM_WORDS];
	logic [$clog2(soc_pkg::ROM_WORDS)-1:0] index;

	initial begin
		$readmemh("rtl/boot_rom.hex", rom);
	end

	// Low word-address bits only, higher offsets alias
	assign index = i_address.word_view.word[$clog2(soc_pkg::ROM_WORDS)-1:0];

	// Writes are acked like reads and have no effect
	always_ff @(posedge clock) begin
		o_ready <= i_request;
		if (i_request) begin
			o_rdata <= rom[index];
		end
	end

endmodule

// File: rtl/bus_controller.sv
module bus_controller (
	input  logic                            clock,
	input  logic                            i_reset,

	// Master side
	input  logic                            i_request,
	input  logic                            i_rw,
	input  soc_pkg::bus_address_t           i_address,
	input  logic [soc_pkg::DATA_WIDTH-1:0]  i_wdata,
	output logic [soc_pkg::DATA_WIDTH-1:0]  o_rdata,
	output logic                            o_ready,
	output logic                            o_fault,

	// Target side
	output logic                            o_target_rw,
	output soc_pkg::bus_address_t           o_target_address,
	output logic [soc_pkg::DATA_WIDTH-1:0]  o_target_wdata,
	output logic                            o_rom_request,
	output logic                            o_ram_request,
	output logic                            o_timer_request,
	input  logic                            i_rom_ready,
	input  logic [soc_pkg::DATA_WIDTH-1:0]  i_rom_rdata,
	input  logic                            i_ram_ready,
	input  logic [soc_pkg::DATA_WIDTH-1:0]  i_ram_rdata,
	input  logic                            i_timer_ready,
	input  logic [soc_pkg::DATA_WIDTH-1:0]  i_timer_rdata
);

	logic [1:0] state;

	// Region decode of the latched address
	logic sel_rom;
	logic sel_ram;
	logic sel_timer;
	logic sel_none;

	// Internal stand-in target for unmapped regions
	logic fault_strobe;
	logic fault_ack;

	logic                           target_done;
	logic [soc_pkg::DATA_WIDTH-1:0] response_data;

	always_comb begin
		sel_rom   = o_target_address.region_view.region == soc_pkg::REGION_ROM;
		sel_ram   = o_target_address.region_view.region == soc_pkg::REGION_RAM;
		sel_timer = o_target_address.region_view.region == soc_pkg::REGION_TIMER;
		sel_none  = !(sel_rom || sel_ram || sel_timer);
	end

	assign target_done = i_rom_ready | i_ram_ready | i_timer_ready | fault_ack;

	// Only one target answers, fault path leaves data at zero
	always_comb begin
		if (i_rom_ready) begin
			response_data = i_rom_rdata;
		end else if (i_ram_ready) begin
			response_data = i_ram_rdata;
		end else if (i_timer_ready) begin
			response_data = i_timer_rdata;
		end else begin
			response_data = '0;
		end
	end

	// ======================================================================
	// Transaction FSM
	// ======================================================================

	always_ff @(posedge clock) begin
		if (i_reset) begin
			state           <= soc_pkg::BUS_STATE_IDLE;
			o_ready         <= 1'b0;
			o_fault         <= 1'b0;
			o_rom_request   <= 1'b0;
			o_ram_request   <= 1'b0;
			o_timer_request <= 1'b0;
			fault_strobe    <= 1'b0;
			fault_ack       <= 1'b0;
		end else begin
			// Strobes and response flags last one cycle
			o_rom_request   <= 1'b0;
			o_ram_request   <= 1'b0;
			o_timer_request <= 1'b0;
			fault_strobe    <= 1'b0;
			o_ready         <= 1'b0;
			o_fault         <= 1'b0;
			fault_ack       <= fault_strobe;

			case (state)
				soc_pkg::BUS_STATE_IDLE: begin
					if (i_request) begin
						state <= soc_pkg::BUS_STATE_STROBE;
					end
				end
				soc_pkg::BUS_STATE_STROBE: begin
					o_rom_request   <= sel_rom;
					o_ram_request   <= sel_ram;
					o_timer_request <= sel_timer;
					fault_strobe    <= sel_none;
					state           <= soc_pkg::BUS_STATE_WAIT;
				end
				soc_pkg::BUS_STATE_WAIT: begin
					if (target_done) begin
						o_ready <= 1'b1;
						o_fault <= fault_ack;
						state   <= soc_pkg::BUS_STATE_RESPOND;
					end
				end
				default: begin
					// Respond cycle, back to idle
					state <= soc_pkg::BUS_STATE_IDLE;
				end
			endcase
		end
	end

	// Request and response payload
	always_ff @(posedge clock) begin
		if (state == soc_pkg::BUS_STATE_IDLE && i_request) begin
			o_target_rw      <= i_rw;
			o_target_address <= i_address;
			o_target_wdata   <= i_wdata;
		end
		if (state == soc_pkg::BUS_STATE_WAIT && target_done) begin
			o_rdata <= response_data;
		end
	end

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

	// ======================================================================
	// Bus widths and address map
	// ======================================================================

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;

	// Region codes live in address bits 31:28
	localparam logic [3:0] REGION_ROM   = 4'h0;
	localparam logic [3:0] REGION_RAM   = 4'h1;
	localparam logic [3:0] REGION_TIMER = 4'hA;

	// Memory sizes in words, offsets beyond these alias
	localparam int ROM_WORDS = 16;
	localparam int RAM_WORDS = 256;

	// ======================================================================
	// Machine timer
	// ======================================================================

	localparam int TIMER_WIDTH        = 64;
	localparam int TIMER_TICK_DIVIDER = 4;

	localparam logic [2:0] TIMER_REG_TIME_LO = 3'd0;
	localparam logic [2:0] TIMER_REG_TIME_HI = 3'd1;
	localparam logic [2:0] TIMER_REG_CMP_LO  = 3'd2;
	localparam logic [2:0] TIMER_REG_CMP_HI  = 3'd3;

	// Bus controller state encoding
	localparam logic [1:0] BUS_STATE_IDLE    = 2'd0;
	localparam logic [1:0] BUS_STATE_STROBE  = 2'd1;
	localparam logic [1:0] BUS_STATE_WAIT    = 2'd2;
	localparam logic [1:0] BUS_STATE_RESPOND = 2'd3;

	// Same address word seen by the decoder and by the targets
	typedef union packed {
		struct packed {
			logic [3:0]            region;
			logic [ADDR_WIDTH-5:0] offset;
		} region_view;
		struct packed {
			logic [ADDR_WIDTH-3:0] word;
			logic [1:0]            lane;
		} word_view;
	} bus_address_t;

endpackage
